// File: hw/zport_pkg.sv
package zport_pkg;

	typedef logic [7:0] byte_t;

	//////////////////////////////
	// port addresses

	localparam byte_t port_fe = 8'hFE;  // border, beeper, keys
	localparam byte_t port_fd = 8'hFD;
	localparam byte_t port_f7 = 8'hF7;
	localparam byte_t port_ef = 8'hEF;  // xt read-back
	localparam byte_t port_0f = 8'h0F;
	localparam byte_t port_1f = 8'h1F;  // soundrive 1 on write, joystick on read
	localparam byte_t port_4f = 8'h4F;
	localparam byte_t port_5f = 8'h5F;
	localparam byte_t port_fb = 8'hFB;  // covox
	localparam byte_t port_dd = 8'hDD;  // covox, second address
	localparam byte_t port_df = 8'hDF;  // mouse

	localparam logic [15:0] port_xt = 16'h55FF;  // full 16-bit match

	localparam byte_t xt_unlock_default = 8'hAA;

	//////////////////////////////
	// decoded port of the current access

	typedef enum logic [3:0] {
		sel_none,
		sel_fe,
		sel_7ffd,
		sel_fd_other,
		sel_eff7,
		sel_f7_other,
		sel_xt,
		sel_xtrd,
		sel_sd0,
		sel_sd1_kjoy,
		sel_sd2,
		sel_sd3,
		sel_covox,
		sel_mouse
	} port_sel_e;

	// xt register numbers, only some of them are implemented here
	typedef enum logic [7:0] {
		xborder   = 8'h00,
		sysconfig = 8'h01,
		romconfig = 8'h02,
		vpage     = 8'h03,
		page00    = 8'h04,
		page01    = 8'h05,
		page10    = 8'h06,
		page11    = 8'h07,
		vconfig   = 8'h08,
		paladdr   = 8'h09,
		paldata   = 8'h0A,
		sfaddr    = 8'h0B,
		sfdata    = 8'h0C
	} xt_reg_e;

	typedef enum logic [1:0] {
		xt_locked,
		xt_addr_phase,
		xt_data_phase
	} xt_state_e;

endpackage

// File: hw/zbus_decode.sv
`timescale 1ns/1ps

module zbus_decode (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output logic                  port_wr,
	output logic                  port_rd,
	output zport_pkg::port_sel_e  sel,
	output logic                  porthit
);

	import zport_pkg::*;

	logic  iowr_reg;  // io write seen last cycle
	logic  iord_reg;
	logic  iowr_now;
	logic  iord_now;
	byte_t loa;

	assign loa = a[7:0];

	assign iowr_now = ~(iorq_n | wr_n);
	assign iord_now = ~(iorq_n | rd_n);

	//////////////////////////////
	// one strobe per io cycle

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= iowr_now;
			iord_reg <= iord_now;
			port_wr  <= iowr_now & ~iowr_reg;  // rising edge of the cycle only
			port_rd  <= iord_now & ~iord_reg;
		end
	end

	//////////////////////////////
	// address decode

	always_comb
	begin
		case (loa)
			port_fe: sel = sel_fe;
			port_fd: sel = a[15] ? sel_fd_other : sel_7ffd;  // 7ffd needs a15 low
			port_f7: sel = a[12] ? sel_f7_other : sel_eff7;  // eff7 needs a12 low
			port_ef: sel = sel_xtrd;
			port_0f: sel = sel_sd0;
			port_1f: sel = sel_sd1_kjoy;
			port_4f: sel = sel_sd2;
			port_5f: sel = sel_sd3;
			port_fb,
			port_dd: sel = sel_covox;
			port_df: sel = sel_mouse;
			default:
			begin
				if (a == port_xt)
					sel = sel_xt;
				else
					sel = sel_none;
			end
		endcase
	end

	// 55FF is handled internally but does not claim the bus
	assign porthit = (sel != sel_none) && (sel != sel_xt);

endmodule

// File: hw/zport_paging.sv
`timescale 1ns/1ps

module zport_paging (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic                  port_wr,
	input  zport_pkg::port_sel_e  sel,
	input  zport_pkg::byte_t      din,
	output zport_pkg::byte_t      p7ffd,
	output zport_pkg::byte_t      peff7,
	output logic                  pent1m_rom,
	output logic [5:0]            pent1m_page,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0
);

	import zport_pkg::*;

	byte_t p7ffd_raw;
	byte_t peff7_raw;
	logic  block1m;    // eff7 bit 2
	logic  block7ffd;  // 48k lock honoured only in 128k mode

	assign block1m   = peff7_raw[2];
	assign block7ffd = p7ffd_raw[5] & block1m;

	//////////////////////////////
	// 7ffd

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_raw <= '0;
		else if (port_wr && (sel == sel_7ffd) && !block7ffd)
			p7ffd_raw <= din;  // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 high page
	end

	//////////////////////////////
	// eff7

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_raw <= '0;
		else if (port_wr && (sel == sel_eff7))
			peff7_raw <= din;
	end

	always_comb
	begin
		p7ffd = p7ffd_raw;
		peff7 = peff7_raw;
		if (block1m)
		begin
			p7ffd[7:5] = 3'b000;  // high page bits meaningless in 128k mode
			peff7[6]   = 1'b0;
			peff7[3:1] = 3'b000;
		end
	end

	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_1m_on  = ~peff7_raw[2];
	assign pent1m_ram0_0 = peff7_raw[3];

endmodule

// File: hw/zport_xt_regs.sv
`timescale 1ns/1ps

module zport_xt_regs #(
	parameter zport_pkg::byte_t xt_unlock_key = zport_pkg::xt_unlock_default
) (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic                  port_wr,
	input  zport_pkg::port_sel_e  sel,
	input  zport_pkg::byte_t      din,
	output logic [5:0]            border,
	output zport_pkg::byte_t      vcfg,
	output zport_pkg::byte_t      sp_wa,
	output logic [5:0]            sp_wd,
	output logic                  sp_ws,
	output zport_pkg::byte_t      sf_wa,
	output zport_pkg::byte_t      sf_wd,
	output logic                  sf_ws,
	output zport_pkg::byte_t      xt_rdata
);

	import zport_pkg::*;

	xt_state_e xt_state;
	xt_reg_e   xt_addr;     // register number from the address phase
	logic      xt_wr;
	logic      xt_data_wr;  // final write of the sequence
	logic      fe_wr;

	assign xt_wr      = port_wr && (sel == sel_xt);
	assign xt_data_wr = xt_wr && (xt_state == xt_data_phase);
	assign fe_wr      = port_wr && (sel == sel_fe);

	//////////////////////////////
	// 55ff sequence: key, address, data

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			xt_state <= xt_locked;
			xt_addr  <= xborder;
		end
		else if (xt_wr)
		begin
			case (xt_state)
				xt_locked:
				begin
					if (din == xt_unlock_key)
						xt_state <= xt_addr_phase;
				end
				xt_addr_phase:
				begin
					xt_addr  <= xt_reg_e'(din);
					xt_state <= xt_data_phase;
				end
				default:
					xt_state <= xt_locked;  // data phase done
			endcase
		end
		else if (port_wr)
			xt_state <= xt_locked;  // any other port breaks the sequence
	end

	//////////////////////////////
	// register writes

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= '0;
			vcfg   <= '0;
			sp_wa  <= '0;
			sp_wd  <= '0;
			sf_wa  <= '0;
			sf_wd  <= '0;
		end
		else if (fe_wr)
			border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};  // grb spread out
		else if (xt_data_wr)
		begin
			case (xt_addr)
				xborder: border <= din[5:0];
				vconfig: vcfg   <= din;
				paladdr: sp_wa  <= din;
				paldata: sp_wd  <= din[5:0];
				sfaddr:  sf_wa  <= din;
				sfdata:  sf_wd  <= din;
				default: ;
			endcase
		end
	end

	// write strobes to palette and sprite memory
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sp_ws <= 1'b0;
			sf_ws <= 1'b0;
		end
		else
		begin
			sp_ws <= xt_data_wr && (xt_addr == paldata);
			sf_ws <= xt_data_wr && (xt_addr == sfdata);
		end
	end

	// only border reads back for now
	assign xt_rdata = (xt_addr == xborder) ? {2'b00, border} : 8'hFF;

endmodule

// File: hw/zport_audio.sv
`timescale 1ns/1ps

module zport_audio (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic                  port_wr,
	input  zport_pkg::port_sel_e  sel,
	input  zport_pkg::byte_t      din,
	output zport_pkg::byte_t      psd0,
	output zport_pkg::byte_t      psd1,
	output zport_pkg::byte_t      psd2,
	output zport_pkg::byte_t      psd3
);

	import zport_pkg::*;

	byte_t beep;  // beeper bit as a full-scale sample

	assign beep = {8{din[4]}};

	//////////////////////////////
	// dac channels

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			psd0 <= '0;
			psd1 <= '0;
			psd2 <= '0;
			psd3 <= '0;
		end
		else if (port_wr)
		begin
			case (sel)
				sel_fe:
				begin
					psd0 <= beep;
					psd1 <= beep;
					psd2 <= beep;
					psd3 <= beep;
				end
				sel_covox:  // mono, all four together
				begin
					psd0 <= din;
					psd1 <= din;
					psd2 <= din;
					psd3 <= din;
				end
				sel_sd0:      psd0 <= din;
				sel_sd1_kjoy: psd1 <= din;
				sel_sd2:      psd2 <= din;
				sel_sd3:      psd3 <= din;
				default: ;
			endcase
		end
	end

endmodule

// File: hw/zport_rdmux.sv
`timescale 1ns/1ps

module zport_rdmux (
	input  zport_pkg::port_sel_e  sel,
	input  logic                  porthit,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic [4:0]            kj_in,
	input  zport_pkg::byte_t      mus_in,
	input  zport_pkg::byte_t      xt_rdata,
	output zport_pkg::byte_t      dout,
	output logic                  dataout
);

	import zport_pkg::*;

	//////////////////////////////
	// read data

	always_comb
	begin
		case (sel)
			sel_fe:
				dout = {1'b1, tape_read, 1'b0, keys_in};  // keys active low
			sel_sd1_kjoy:
				dout = {3'b000, kj_in};
			sel_mouse:
				dout = mus_in;
			sel_xtrd:
				dout = xt_rdata;
			default:
				dout = 8'hFF;  // f7 and unbacked ports float high
		endcase
	end

	// drive the cpu data bus only on our own read cycles
	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

// File: hw/zports_top.sv
`timescale 1ns/1ps

module zports_top #(
	parameter zport_pkg::byte_t xt_unlock_key = zport_pkg::xt_unlock_default
) (
	input  logic              zclk,
	input  logic              rst_n,
	input  logic [15:0]       a,
	input  zport_pkg::byte_t  din,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic [4:0]        keys_in,
	input  logic              tape_read,
	input  logic [4:0]        kj_in,
	input  zport_pkg::byte_t  mus_in,
	output zport_pkg::byte_t  dout,
	output logic              dataout,
	output logic              porthit,
	output zport_pkg::byte_t  p7ffd,
	output zport_pkg::byte_t  peff7,
	output logic              pent1m_rom,
	output logic [5:0]        pent1m_page,
	output logic              pent1m_1m_on,
	output logic              pent1m_ram0_0,
	output logic [5:0]        border,
	output zport_pkg::byte_t  vcfg,
	output zport_pkg::byte_t  sp_wa,
	output logic [5:0]        sp_wd,
	output logic              sp_ws,
	output zport_pkg::byte_t  sf_wa,
	output zport_pkg::byte_t  sf_wd,
	output logic              sf_ws,
	output zport_pkg::byte_t  psd0,
	output zport_pkg::byte_t  psd1,
	output zport_pkg::byte_t  psd2,
	output zport_pkg::byte_t  psd3
);

	import zport_pkg::*;

	logic      port_wr;
	port_sel_e sel;
	byte_t     xt_rdata;

	//////////////////////////////
	// bus side

	zbus_decode u_decode (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.a       (a),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.port_wr (port_wr),
		.port_rd (),         // no read side effects in this block
		.sel     (sel),
		.porthit (porthit)
	);

	//////////////////////////////
	// register blocks

	zport_paging u_paging (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.port_wr       (port_wr),
		.sel           (sel),
		.din           (din),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_rom    (pent1m_rom),
		.pent1m_page   (pent1m_page),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	zport_xt_regs #(
		.xt_unlock_key (xt_unlock_key)
	) u_xt_regs (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.port_wr  (port_wr),
		.sel      (sel),
		.din      (din),
		.border   (border),
		.vcfg     (vcfg),
		.sp_wa    (sp_wa),
		.sp_wd    (sp_wd),
		.sp_ws    (sp_ws),
		.sf_wa    (sf_wa),
		.sf_wd    (sf_wd),
		.sf_ws    (sf_ws),
		.xt_rdata (xt_rdata)
	);

	zport_audio u_audio (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.port_wr (port_wr),
		.sel     (sel),
		.din     (din),
		.psd0    (psd0),
		.psd1    (psd1),
		.psd2    (psd2),
		.psd3    (psd3)
	);

	zport_rdmux u_rdmux (
		.sel       (sel),
		.porthit   (porthit),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.xt_rdata  (xt_rdata),
		.dout      (dout),
		.dataout   (dataout)
	);

endmodule

// File: test/tb_zports.sv
`timescale 1ns/1ps

module tb_zports;

	import zport_pkg::*;

	localparam int    clk_period_ns    = 100;
	localparam int    bus_cycles       = 37;   // io_write and io_read calls below
	localparam int    clocks_per_cycle = 5;
	localparam int    margin_clocks    = 50;   // reset and input setup
	localparam byte_t xt_key           = xt_unlock_default;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	byte_t       din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	byte_t       mus_in;
	byte_t       dout;
	logic        dataout;
	logic        porthit;
	byte_t       p7ffd;
	byte_t       peff7;
	logic        pent1m_rom;
	logic [5:0]  pent1m_page;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic [5:0]  border;
	byte_t       vcfg;
	byte_t       sp_wa;
	logic [5:0]  sp_wd;
	logic        sp_ws;
	byte_t       sf_wa;
	byte_t       sf_wd;
	logic        sf_ws;
	byte_t       psd0;
	byte_t       psd1;
	byte_t       psd2;
	byte_t       psd3;

	byte_t exp_sd [4];       // expected dac channels
	int    sp_ws_seen = 0;   // strobe samples at falling edges
	int    sf_ws_seen = 0;

	zports_top u_zports_top (
		.zclk          (zclk),
		.rst_n         (rst_n),
		.a             (a),
		.din           (din),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.keys_in       (keys_in),
		.tape_read     (tape_read),
		.kj_in         (kj_in),
		.mus_in        (mus_in),
		.dout          (dout),
		.dataout       (dataout),
		.porthit       (porthit),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_rom    (pent1m_rom),
		.pent1m_page   (pent1m_page),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.border        (border),
		.vcfg          (vcfg),
		.sp_wa         (sp_wa),
		.sp_wd         (sp_wd),
		.sp_ws         (sp_ws),
		.sf_wa         (sf_wa),
		.sf_wd         (sf_wd),
		.sf_ws         (sf_ws),
		.psd0          (psd0),
		.psd1          (psd1),
		.psd2          (psd2),
		.psd3          (psd3)
	);

	initial
		zclk = 1'b0;

	always #(clk_period_ns / 2) zclk = ~zclk;

	always @(negedge zclk)
	begin
		if (sp_ws)
			sp_ws_seen++;
		if (sf_ws)
			sf_ws_seen++;
	end

	//////////////////////////////
	// reporting

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			abort_run("byte value mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			abort_run("bit value mismatch");
		end
	endtask

	task automatic check_six(input string name, input logic [5:0] expected,
			input logic [5:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			abort_run("6-bit value mismatch");
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			abort_run("strobe count mismatch");
		end
	endtask

	task automatic check_dacs();
		check_byte("psd0", exp_sd[0], psd0);
		check_byte("psd1", exp_sd[1], psd1);
		check_byte("psd2", exp_sd[2], psd2);
		check_byte("psd3", exp_sd[3], psd3);
	endtask

	function automatic void fill_dacs(input byte_t value);
		for (int i = 0; i < 4; i++)
			exp_sd[i] = value;
	endfunction

	//////////////////////////////
	// z80 io cycles

	task automatic io_write(input logic [15:0] addr, input byte_t data);
		@(posedge zclk);
		a      <= addr;
		din    <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (3)
		begin
			@(negedge zclk);
			check_bit("dataout", 1'b0, dataout);  // never drive the bus on a write
			@(posedge zclk);
		end
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		@(posedge zclk);
	endtask

	task automatic io_read(input logic [15:0] addr, output byte_t data, output logic de,
			output logic hit);
		@(posedge zclk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(negedge zclk);  // read path is combinational
		data = dout;
		de   = dataout;
		hit  = porthit;
		repeat (3) @(posedge zclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		@(posedge zclk);
	endtask

	task automatic xt_write(input byte_t reg_num, input byte_t data);
		io_write(16'h55FF, xt_key);
		io_write(16'h55FF, reg_num);
		io_write(16'h55FF, data);
	endtask

	//////////////////////////////
	// directed tests

	task automatic test_reset_fe();
		byte_t      d;
		byte_t      rd;
		logic       de;
		logic       hit;
		logic [4:0] k;
		logic       t;
		check_byte("p7ffd", 8'h00, p7ffd);
		check_byte("peff7", 8'h00, peff7);
		check_six("border", 6'h00, border);
		check_byte("vcfg", 8'h00, vcfg);
		check_byte("sp_wa", 8'h00, sp_wa);
		check_six("sp_wd", 6'h00, sp_wd);
		check_byte("sf_wa", 8'h00, sf_wa);
		check_byte("sf_wd", 8'h00, sf_wd);
		check_bit("sp_ws", 1'b0, sp_ws);
		check_bit("sf_ws", 1'b0, sf_ws);
		check_bit("pent1m_1m_on", 1'b1, pent1m_1m_on);
		check_bit("dataout", 1'b0, dataout);
		fill_dacs(8'h00);
		check_dacs();
		d = 8'($urandom);
		io_write(16'h00FE, d);
		check_six("border", {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0}, border);
		fill_dacs({8{d[4]}});  // beeper on every channel
		check_dacs();
		k = 5'($urandom);
		t = 1'($urandom);
		@(posedge zclk);
		keys_in   <= k;
		tape_read <= t;
		io_read(16'h7FFE, rd, de, hit);
		check_byte("dout", {1'b1, t, 1'b0, k}, rd);
		check_bit("dataout", 1'b1, de);
	endtask

	task automatic test_sound();
		logic [15:0] sd_port [4];
		byte_t       d;
		sd_port = '{16'h000F, 16'h001F, 16'h004F, 16'h005F};
		for (int i = 0; i < 4; i++)
		begin
			d = 8'($urandom);
			io_write(sd_port[i], d);
			exp_sd[i] = d;
			check_dacs();
		end
		d = 8'($urandom);
		io_write(16'h00FB, d);
		fill_dacs(d);
		check_dacs();
		d = 8'($urandom);
		io_write(16'h00DD, d);
		fill_dacs(d);
		check_dacs();
	endtask

	task automatic test_paging();
		byte_t d;
		byte_t d2;
		byte_t e;
		d = 8'($urandom) & 8'hDF;  // lock bit clear
		io_write(16'h7FFD, d);
		check_byte("p7ffd", d, p7ffd);
		check_six("pent1m_page", {d[7:5], d[2:0]}, pent1m_page);
		check_bit("pent1m_rom", d[4], pent1m_rom);
		io_write(16'hBFFD, ~d);  // a15 high so not 7ffd
		check_byte("p7ffd", d, p7ffd);
		io_write(16'h1FF7, 8'hFF);  // a12 high so not eff7
		check_byte("peff7", 8'h00, peff7);
		check_bit("pent1m_1m_on", 1'b1, pent1m_1m_on);
		e = 8'($urandom) | 8'h04;
		io_write(16'hEFF7, e);
		check_byte("peff7", e & 8'hB1, peff7);
		check_byte("p7ffd", d & 8'h1F, p7ffd);
		check_bit("pent1m_1m_on", 1'b0, pent1m_1m_on);
		check_bit("pent1m_ram0_0", e[3], pent1m_ram0_0);
		check_six("pent1m_page", {d[7:5], d[2:0]}, pent1m_page);
		// set the lock and then try to move away
		d2 = 8'($urandom) | 8'h20;
		io_write(16'h7FFD, d2);
		check_byte("p7ffd", d2 & 8'h1F, p7ffd);
		check_bit("pent1m_rom", d2[4], pent1m_rom);
		io_write(16'h7FFD, ~d2);
		check_byte("p7ffd", d2 & 8'h1F, p7ffd);
		check_six("pent1m_page", {d2[7:5], d2[2:0]}, pent1m_page);
		check_bit("pent1m_rom", d2[4], pent1m_rom);
	endtask

	task automatic test_xt();
		byte_t b;
		byte_t v;
		byte_t rd;
		logic  de;
		logic  hit;
		int    sp_before;
		int    sf_before;
		b = 8'($urandom);
		xt_write(8'h00, b);  // xborder
		check_six("border", b[5:0], border);
		io_read(16'h12EF, rd, de, hit);
		check_byte("dout", {2'b00, b[5:0]}, rd);
		check_bit("dataout", 1'b1, de);
		sp_before = sp_ws_seen;
		sf_before = sf_ws_seen;
		b = 8'($urandom);
		xt_write(8'h0A, b);  // paldata
		check_six("sp_wd", b[5:0], sp_wd);
		check_count("sp_ws pulses", sp_before + 1, sp_ws_seen);
		check_count("sf_ws pulses", sf_before, sf_ws_seen);
		check_bit("sp_ws", 1'b0, sp_ws);
		b = 8'($urandom);
		xt_write(8'h0C, b);  // sfdata
		check_byte("sf_wd", b, sf_wd);
		check_count("sf_ws pulses", sf_before + 1, sf_ws_seen);
		check_count("sp_ws pulses", sp_before + 1, sp_ws_seen);
		check_bit("sf_ws", 1'b0, sf_ws);
		// top bit clear keeps these apart from the key
		v = 8'($urandom) & 8'h7F;
		xt_write(8'h08, v);
		check_byte("vcfg", v, vcfg);
		io_write(16'h55FF, xt_key);
		io_write(16'h55FF, 8'h08);
		io_write(16'h00FE, 8'h00);  // breaks the sequence
		io_write(16'h55FF, ~v & 8'h7F);
		check_byte("vcfg", v, vcfg);
		io_write(16'h55FF, 8'h08);  // no key first
		io_write(16'h55FF, (~v & 8'h7F) ^ 8'h11);
		check_byte("vcfg", v, vcfg);
	endtask

	task automatic test_read_side();
		logic [4:0] k;
		byte_t      m;
		byte_t      rd;
		logic       de;
		logic       hit;
		k = 5'($urandom);
		m = 8'($urandom);
		@(posedge zclk);
		kj_in  <= k;
		mus_in <= m;
		io_read(16'h001F, rd, de, hit);
		check_byte("dout", {3'b000, k}, rd);
		check_bit("dataout", 1'b1, de);
		io_read(16'hFBDF, rd, de, hit);
		check_byte("dout", m, rd);
		check_bit("dataout", 1'b1, de);
		io_read(16'h0033, rd, de, hit);
		check_bit("porthit", 1'b0, hit);
		check_bit("dataout", 1'b0, de);
		io_read(16'h12F7, rd, de, hit);
		check_byte("dout", 8'hFF, rd);
		check_bit("porthit", 1'b1, hit);
	endtask

	//////////////////////////////
	// run

	initial
	begin
		#((bus_cycles * clocks_per_cycle + margin_clocks) * clk_period_ns);
		abort_run("watchdog timeout, tests did not finish in time");
	end

	initial
	begin
		void'($urandom(17543));
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		keys_in   = 5'h1F;  // no key pressed
		tape_read = 1'b0;
		kj_in     = 5'h00;
		mus_in    = 8'hFF;
		repeat (5) @(posedge zclk);
		rst_n <= 1'b1;
		@(posedge zclk);
		test_reset_fe();
		test_sound();
		test_paging();
		test_xt();
		test_read_side();
		$display("test passed");
		$finish;
	end

endmodule

// File: vlog.f
hw/zport_pkg.sv
hw/zbus_decode.sv
hw/zport_paging.sv
hw/zport_xt_regs.sv
hw/zport_audio.sv
hw/zport_rdmux.sv
hw/zports_top.sv
test/tb_zports.sv
